// File: hdl/cachePkg.sv
package cachePkg;

	parameter int numWays = 4;
	parameter int numSets = 64;
	parameter int wordsPerLine = 4;

	// tag from bits 28:10, index from 9:4 and word from 3:2
	parameter int wordLsb = 2;
	parameter int wordBits = 2;
	parameter int indexLsb = 4;
	parameter int indexBits = 6;
	parameter int tagLsb = 10;
	parameter int tagBits = 19;

	typedef logic [tagBits-1:0] tagT;
	typedef logic [indexBits-1:0] indexT;
	typedef logic [wordBits-1:0] wordT;
	typedef logic [numWays-1:0] wayMaskT;

	// one bit per way pair (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	// bit clear means the lower way is more recent
	typedef logic [5:0] lruT;

	function automatic lruT lruTouch(lruT lru, wayMaskT way);
		lruT res;
		int b;
		res = lru;
		b = 0;
		for (int i = 0; i < numWays; i++) begin
			for (int j = i + 1; j < numWays; j++) begin
				if (way[i])
					res[b] = 1'b0;
				else if (way[j])
					res[b] = 1'b1;
				b++;
			end
		end
		return res;
	endfunction

	function automatic wayMaskT lruVictim(lruT lru);
		wayMaskT res;
		int b;
		res = '1;
		b = 0;
		// drop every way that is more recent than some other way
		for (int i = 0; i < numWays; i++) begin
			for (int j = i + 1; j < numWays; j++) begin
				if (lru[b])
					res[j] = 1'b0;
				else
					res[i] = 1'b0;
				b++;
			end
		end
		return res;
	endfunction

endpackage

// File: hdl/busPkg.sv
package busPkg;

	typedef enum logic {
		cacheable,
		uncached
	} areaT;

	typedef enum logic [1:0] {
		opIdle,
		opRead,
		opWrite,
		opFill
	} memOpT;

	// word position within a burst
	typedef logic [1:0] beatT;

endpackage

// File: hdl/cacheIfs.sv
interface arrayWriteIf #(
	parameter int dataWidth = 32
);
	import cachePkg::*;

	logic fill;
	logic hitWrite;
	logic touch;
	wayMaskT way;
	indexT index;
	tagT tag;
	wordT word;
	logic [dataWidth-1:0] data;
	logic [dataWidth/8-1:0] byteEn;

	modport master (output fill, hitWrite, touch, way, index, tag, word, data, byteEn);
	modport slave (input fill, hitWrite, touch, way, index, tag, word, data, byteEn);

endinterface

interface memPortIf #(
	parameter int addrWidth = 32,
	parameter int dataWidth = 32
);
	import busPkg::*;

	logic start;
	memOpT op;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] wdata;
	logic [dataWidth/8-1:0] be;
	logic beatDone;
	beatT beatWord;
	logic [dataWidth-1:0] rdata;
	logic done;

	modport master (output start, op, addr, wdata, be, input beatDone, beatWord, rdata, done);
	modport slave (input start, op, addr, wdata, be, output beatDone, beatWord, rdata, done);

endinterface

// File: hdl/cacheArray.sv
module cacheArray #(
	parameter int addrWidth = 32,
	parameter int dataWidth = 32
) (
	input logic CLK,
	input logic RST_N,
	input logic [addrWidth-1:0] lookupAddr,
	output cachePkg::wayMaskT hit,
	output logic [dataWidth-1:0] hitData,
	output cachePkg::wayMaskT victim,
	arrayWriteIf.slave wr
);
	import cachePkg::*;

	localparam int numLanes = dataWidth / 8;
	localparam int locBits = indexBits + wordBits;

	tagT tagArr [numWays][numSets];
	logic validArr [numWays][numSets];
	logic [numLanes-1:0][7:0] dataArr [numWays][numSets*wordsPerLine];
	lruT lruArr [numSets];

	indexT lkIndex;
	tagT lkTag;
	logic [locBits-1:0] lkLoc;
	logic [locBits-1:0] wrLoc;

	assign lkIndex = lookupAddr[indexLsb +: indexBits];
	assign lkTag = lookupAddr[tagLsb +: tagBits];
	assign lkLoc = lookupAddr[wordLsb +: locBits];
	assign wrLoc = {wr.index, wr.word};

	// all four ways compared in parallel
	always_comb begin
		hitData = '0;
		for (int w = 0; w < numWays; w++) begin
			hit[w] = validArr[w][lkIndex] && (tagArr[w][lkIndex] == lkTag);
		end
		for (int w = 0; w < numWays; w++) begin
			if (hit[w])
				hitData = dataArr[w][lkLoc];
		end
	end

	assign victim = lruVictim(lruArr[lkIndex]);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			tagArr <= '{default: '0};
			validArr <= '{default: '0};
			dataArr <= '{default: '0};
			lruArr <= '{default: '0};
		end else begin
			for (int w = 0; w < numWays; w++) begin
				if (wr.way[w]) begin
					if (wr.fill) begin
						dataArr[w][wrLoc] <= wr.data;
						tagArr[w][wr.index] <= wr.tag;
						validArr[w][wr.index] <= 1'b1;
					end else if (wr.hitWrite) begin
						for (int b = 0; b < numLanes; b++) begin
							if (wr.byteEn[b])
								dataArr[w][wrLoc][b] <= wr.data[8*b +: 8];
						end
					end
				end
			end

			// accessed way becomes most recent
			if (wr.fill || wr.hitWrite || wr.touch)
				lruArr[wr.index] <= lruTouch(lruArr[wr.index], wr.way);
		end
	end

endmodule

// File: hdl/cacheControl.sv
module cacheControl #(
	parameter int addrWidth = 32,
	parameter int dataWidth = 32
) (
	input logic CLK,
	input logic RST_N,
	input logic [addrWidth-1:0] cpuAddr,
	input logic [dataWidth-1:0] cpuWdata,
	input logic [dataWidth/8-1:0] cpuBe,
	input logic cpuWr,
	input logic cpuReq,
	input logic cacheEnable,
	input cachePkg::wayMaskT hit,
	input logic [dataWidth-1:0] hitData,
	input cachePkg::wayMaskT victim,
	output logic cpuBusy,
	output logic [dataWidth-1:0] cpuRdata,
	arrayWriteIf.master arr,
	memPortIf.master mem
);
	import cachePkg::*;
	import busPkg::*;

	typedef enum logic [1:0] {
		idle,
		waitMem,
		fillLine
	} stateT;

	stateT state;
	areaT area;
	logic readHit;
	logic writeHit;
	logic startReq;
	logic filling;

	tagT fillTag;
	indexT fillIndex;
	wayMaskT fillWay;
	logic [dataWidth-1:0] rdWord;

	// only the lowest area is cacheable and only when enabled
	assign area = (cpuAddr[addrWidth-1 -: 3] == 3'b000 && cacheEnable) ? cacheable : uncached;
	assign readHit = cpuReq && !cpuWr && area == cacheable && (|hit);
	assign writeHit = cpuReq && cpuWr && area == cacheable && (|hit);
	assign startReq = state == idle && cpuReq && !readHit;
	assign filling = state == fillLine;

	assign mem.start = startReq;
	assign mem.addr = cpuAddr;
	assign mem.wdata = cpuWdata;
	assign mem.be = cpuBe;

	always_comb begin
		if (cpuWr)
			mem.op = opWrite;
		else if (area == cacheable)
			mem.op = opFill;
		else
			mem.op = opRead;
	end

	// fill beats take the latched line and all else the live request
	assign arr.fill = filling && mem.beatDone;
	assign arr.hitWrite = state == idle && writeHit;
	assign arr.touch = state == idle && readHit;
	assign arr.way = filling ? fillWay : hit;
	assign arr.index = filling ? fillIndex : cpuAddr[indexLsb +: indexBits];
	assign arr.tag = filling ? fillTag : cpuAddr[tagLsb +: tagBits];
	assign arr.word = filling ? mem.beatWord : cpuAddr[wordLsb +: wordBits];
	assign arr.data = filling ? mem.rdata : cpuWdata;
	assign arr.byteEn = filling ? '1 : cpuBe;

	// done arrives the cycle after the last beat
	assign cpuBusy = (state == idle) ? (cpuReq && !readHit) : !mem.done;
	assign cpuRdata = (state == waitMem) ? rdWord : hitData;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= idle;
		end else begin
			case (state)
				idle: begin
					if (startReq)
						state <= (mem.op == opFill) ? fillLine : waitMem;
				end
				waitMem, fillLine: begin
					if (mem.done)
						state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (startReq) begin
			fillTag <= cpuAddr[tagLsb +: tagBits];
			fillIndex <= cpuAddr[indexLsb +: indexBits];
			fillWay <= victim;
		end
		if (state == waitMem && mem.beatDone)
			rdWord <= mem.rdata;
	end

endmodule

// File: hdl/busMaster.sv
module busMaster #(
	parameter int addrWidth = 32,
	parameter int dataWidth = 32
) (
	input logic CLK,
	input logic RST_N,
	input logic [dataWidth-1:0] memRdata,
	input logic memWait,
	output logic [addrWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWdata,
	output logic [dataWidth/8-1:0] memBe,
	output logic memWe,
	output logic memReq,
	output logic memLock,
	memPortIf.slave mem
);
	import busPkg::*;

	memOpT curOp;
	beatT beatCnt;
	beatT startWord;
	logic accept;
	logic beat;
	logic lastBeat;
	logic doneR;

	assign accept = mem.start && !memReq;
	assign beat = memReq && !memWait;
	assign lastBeat = curOp != opFill || beatCnt == 2'd3;

	// burst begins one word past the requested one
	assign startWord = mem.addr[3:2] + 2'd1;

	assign mem.beatDone = beat;
	assign mem.beatWord = memAddr[3:2];
	assign mem.rdata = memRdata;
	assign mem.done = doneR;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			memReq <= 1'b0;
			memWe <= 1'b0;
			memLock <= 1'b0;
			curOp <= opIdle;
			beatCnt <= '0;
			doneR <= 1'b0;
		end else begin
			doneR <= 1'b0;
			if (accept) begin
				memReq <= 1'b1;
				memWe <= mem.op == opWrite;
				memLock <= mem.op == opFill;
				curOp <= mem.op;
				beatCnt <= '0;
			end else if (beat) begin
				if (lastBeat) begin
					memReq <= 1'b0;
					memWe <= 1'b0;
					curOp <= opIdle;
					doneR <= 1'b1;
				end else begin
					beatCnt <= beatCnt + 2'd1;
					// unlock for the final beat
					if (beatCnt == 2'd2)
						memLock <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			memWdata <= mem.wdata;
			memBe <= (mem.op == opFill) ? '1 : mem.be;
			memAddr <= (mem.op == opFill) ? {mem.addr[addrWidth-1:4], startWord, 2'b00} : mem.addr;
		end else if (beat && !lastBeat) begin
			memAddr[3:2] <= memAddr[3:2] + 2'd1;
		end
	end

endmodule

// File: hdl/cpuCache.sv
module cpuCache #(
	parameter int addrWidth = 32,
	parameter int dataWidth = 32
) (
	input logic CLK,
	input logic RST_N,

	input logic [addrWidth-1:0] cpuAddr,
	input logic [dataWidth-1:0] cpuWdata,
	input logic [dataWidth/8-1:0] cpuBe,
	input logic cpuWr,
	input logic cpuReq,
	output logic [dataWidth-1:0] cpuRdata,
	output logic cpuBusy,

	output logic [addrWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWdata,
	output logic [dataWidth/8-1:0] memBe,
	output logic memWe,
	output logic memReq,
	output logic memLock,
	input logic [dataWidth-1:0] memRdata,
	input logic memWait,

	input logic cacheEnable
);
	import cachePkg::*;

	wayMaskT hit;
	wayMaskT victim;
	logic [dataWidth-1:0] hitData;

	arrayWriteIf #(.dataWidth(dataWidth)) arrWrite ();
	memPortIf #(.addrWidth(addrWidth), .dataWidth(dataWidth)) memPort ();

	cacheControl #(
		.addrWidth(addrWidth),
		.dataWidth(dataWidth)
	) u_control (
		.CLK(CLK),
		.RST_N(RST_N),
		.cpuAddr(cpuAddr),
		.cpuWdata(cpuWdata),
		.cpuBe(cpuBe),
		.cpuWr(cpuWr),
		.cpuReq(cpuReq),
		.cacheEnable(cacheEnable),
		.hit(hit),
		.hitData(hitData),
		.victim(victim),
		.cpuBusy(cpuBusy),
		.cpuRdata(cpuRdata),
		.arr(arrWrite),
		.mem(memPort)
	);

	// lookup runs on the live CPU address
	cacheArray #(
		.addrWidth(addrWidth),
		.dataWidth(dataWidth)
	) u_array (
		.CLK(CLK),
		.RST_N(RST_N),
		.lookupAddr(cpuAddr),
		.hit(hit),
		.hitData(hitData),
		.victim(victim),
		.wr(arrWrite)
	);

	busMaster #(
		.addrWidth(addrWidth),
		.dataWidth(dataWidth)
	) u_bus (
		.CLK(CLK),
		.RST_N(RST_N),
		.memRdata(memRdata),
		.memWait(memWait),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memBe(memBe),
		.memWe(memWe),
		.memReq(memReq),
		.memLock(memLock),
		.mem(memPort)
	);

endmodule

// File: dv/clockGen.sv
module clockGen #(
	parameter int halfPeriod = 20,
	parameter int resetCycles = 2
) (
	output logic CLK,
	output logic RST_N
);
	timeunit 1ns;
	timeprecision 1ns;

	initial begin
		CLK = 1'b0;
		forever #halfPeriod CLK = ~CLK;
	end

	initial begin
		RST_N = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		RST_N <= 1'b1;
	end

endmodule

// File: dv/memModel.sv
module memModel (
	input logic CLK,
	input logic [31:0] memAddr,
	input logic [31:0] memWdata,
	input logic [3:0] memBe,
	input logic memWe,
	input logic memReq,
	input logic memLock,
	output logic [31:0] memRdata,
	output logic memWait,
	output int reqCount,
	output int burstCount
);
	timeunit 1ns;
	timeprecision 1ns;

	logic [31:0] store [logic [31:0]];
	int seed;
	int waitLeft;
	logic prevReq;
	logic inBurst;

	// unwritten words follow a pattern of the full address
	function automatic logic [31:0] readWord(logic [31:0] a);
		if (store.exists(a))
			return store[a];
		return {a[15:0], a[31:16]} ^ (a >> 3) ^ 32'h5ac3_3c5a;
	endfunction

	initial begin
		logic [31:0] key;
		logic [31:0] w;
		seed = 32'hcfe0_a1fa;
		memRdata = '0;
		memWait = 1'b1;
		reqCount = 0;
		burstCount = 0;
		waitLeft = 0;
		prevReq = 1'b0;
		inBurst = 1'b0;
		forever begin
			@(posedge CLK);
			key = {memAddr[31:2], 2'b00};
			if (memReq && !prevReq)
				reqCount <= reqCount + 1;
			prevReq <= memReq;
			if (memReq && !memWait) begin
				if (memWe) begin
					w = readWord(key);
					for (int b = 0; b < 4; b++) begin
						if (memBe[b])
							w[8*b +: 8] = memWdata[8*b +: 8];
					end
					store[key] = w;
				end
				// a burst starts on the first locked beat
				if (memLock && !inBurst)
					burstCount <= burstCount + 1;
				inBurst <= memLock;
				memWait <= 1'b1;
				waitLeft <= $random(seed) & 7;
			end else if (memReq) begin
				if (waitLeft == 0) begin
					memRdata <= readWord(key);
					memWait <= 1'b0;
				end else begin
					waitLeft <= waitLeft - 1;
				end
			end
		end
	end

endmodule

// File: dv/cacheTb.sv
module cacheTb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int maxRequests = 60;
	// four beats each with up to eight wait cycles plus a little overhead
	localparam int cyclesPerRequest = 4 * (8 + 2);
	localparam int timeoutCycles = maxRequests * cyclesPerRequest + 1600;

	logic CLK;
	logic RST_N;
	logic [31:0] cpuAddr;
	logic [31:0] cpuWdata;
	logic [3:0] cpuBe;
	logic cpuWr;
	logic cpuReq;
	logic [31:0] cpuRdata;
	logic cpuBusy;
	logic [31:0] memAddr;
	logic [31:0] memWdata;
	logic [3:0] memBe;
	logic memWe;
	logic memReq;
	logic memLock;
	logic [31:0] memRdata;
	logic memWait;
	logic cacheEnable;

	int reqCount;
	int burstCount;
	int reqMark;
	int burstMark;
	int cycles;
	logic [31:0] beats [$];
	logic locks [$];

	// reference memory and tag/LRU model
	logic [31:0] refMem [logic [31:0]];
	logic [18:0] refTag [64][4];
	logic refValid [64][4];
	int order [64][4];

	clockGen clocks (
		.CLK(CLK),
		.RST_N(RST_N)
	);

	memModel extMem (
		.CLK(CLK),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memBe(memBe),
		.memWe(memWe),
		.memReq(memReq),
		.memLock(memLock),
		.memRdata(memRdata),
		.memWait(memWait),
		.reqCount(reqCount),
		.burstCount(burstCount)
	);

	cpuCache #(
		.addrWidth(32),
		.dataWidth(32)
	) i_dut (
		.CLK(CLK),
		.RST_N(RST_N),
		.cpuAddr(cpuAddr),
		.cpuWdata(cpuWdata),
		.cpuBe(cpuBe),
		.cpuWr(cpuWr),
		.cpuReq(cpuReq),
		.cpuRdata(cpuRdata),
		.cpuBusy(cpuBusy),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.memBe(memBe),
		.memWe(memWe),
		.memReq(memReq),
		.memLock(memLock),
		.memRdata(memRdata),
		.memWait(memWait),
		.cacheEnable(cacheEnable)
	);

	// completed beats as seen on the bus
	always @(posedge CLK) begin
		if (memReq && !memWait) begin
			beats.push_back(memAddr);
			locks.push_back(memLock);
		end
	end

	task automatic check(input logic [31:0] got, input logic [31:0] expected, input string what);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] refRead(logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		if (refMem.exists(key))
			return refMem[key];
		return {key[15:0], key[31:16]} ^ (key >> 3) ^ 32'h5ac3_3c5a;
	endfunction

	function automatic void refWrite(logic [31:0] addr, logic [31:0] data, logic [3:0] be);
		logic [31:0] w;
		w = refRead(addr);
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				w[8*b +: 8] = data[8*b +: 8];
		end
		refMem[{addr[31:2], 2'b00}] = w;
	endfunction

	function automatic void initModel();
		for (int s = 0; s < 64; s++) begin
			for (int w = 0; w < 4; w++) begin
				refTag[s][w] = '0;
				refValid[s][w] = 1'b0;
				// after reset way 0 is most recent
				order[s][w] = w;
			end
		end
	endfunction

	function automatic bit isCached(logic [31:0] addr);
		return cacheEnable && addr[31:29] == 3'b000;
	endfunction

	function automatic int findWay(logic [31:0] addr);
		for (int w = 0; w < 4; w++) begin
			if (refValid[addr[9:4]][w] && refTag[addr[9:4]][w] == addr[28:10])
				return w;
		end
		return -1;
	endfunction

	// accessed way moves to the front and the last entry is the victim
	function automatic void touchWay(int idx, int way);
		int pos;
		pos = 0;
		for (int i = 0; i < 4; i++) begin
			if (order[idx][i] == way)
				pos = i;
		end
		for (int i = pos; i > 0; i--)
			order[idx][i] = order[idx][i-1];
		order[idx][0] = way;
	endfunction

	function automatic logic [31:0] lineAddr(int tag);
		return {3'b000, 19'(tag), 6'd9, 4'd0};
	endfunction

	function automatic void markBus();
		beats.delete();
		locks.delete();
		reqMark = reqCount;
		burstMark = burstCount;
	endfunction

	task automatic access(input logic [31:0] addr, input logic wr, input logic [31:0] wdata,
			input logic [3:0] be, output logic [31:0] rdata, output int edges);
		@(posedge CLK);
		cpuAddr <= addr;
		cpuWr <= wr;
		cpuWdata <= wdata;
		cpuBe <= be;
		cpuReq <= 1'b1;
		edges = 0;
		do begin
			@(posedge CLK);
			edges++;
		end while (cpuBusy);
		rdata = cpuRdata;
		cpuReq <= 1'b0;
	endtask

	task automatic setEnable(input logic en);
		@(posedge CLK);
		cacheEnable <= en;
		@(posedge CLK);
	endtask

	task automatic checkSingle(input logic [31:0] addr);
		check(32'(beats.size()), 1, "beat count");
		check(beats[0], addr, "beat address");
		check(32'(locks[0]), 0, "single beat lock");
		check(reqCount - reqMark, 1, "request count");
		check(burstCount - burstMark, 0, "burst count");
	endtask

	task automatic checkBurst(input logic [31:0] addr);
		logic [1:0] word;
		check(32'(beats.size()), 4, "burst beat count");
		for (int i = 0; i < 4; i++) begin
			word = addr[3:2] + 2'(i + 1);
			check(beats[i], {addr[31:4], word, 2'b00}, "burst address");
			check(32'(locks[i]), 32'(i < 3), "burst lock");
		end
		check(reqCount - reqMark, 1, "request count");
		check(burstCount - burstMark, 1, "burst count");
	endtask

	task automatic readCheck(input logic [31:0] addr);
		logic [31:0] got;
		int way;
		int idx;
		int edges;
		idx = 32'(addr[9:4]);
		way = findWay(addr);
		markBus();
		access(addr, 1'b0, '0, '0, got, edges);
		check(got, refRead(addr), "read data");
		if (!isCached(addr)) begin
			checkSingle(addr);
		end else if (way >= 0) begin
			check(32'(beats.size()), 0, "beats on a hit");
			check(reqCount - reqMark, 0, "requests on a hit");
			// a hit answers in the request cycle with busy low
			check(edges, 1, "hit latency");
			touchWay(idx, way);
		end else begin
			checkBurst(addr);
			way = order[idx][3];
			refTag[idx][way] = addr[28:10];
			refValid[idx][way] = 1'b1;
			touchWay(idx, way);
		end
	endtask

	task automatic writeCheck(input logic [31:0] addr, input logic [31:0] data, input logic [3:0] be);
		logic [31:0] got;
		int way;
		int edges;
		way = isCached(addr) ? findWay(addr) : -1;
		markBus();
		access(addr, 1'b1, data, be, got, edges);
		refWrite(addr, data, be);
		checkSingle(addr);
		// writes are busy from the first request cycle
		check(32'(edges > 1), 1, "busy on a write");
		// a write hit also counts as a use
		if (way >= 0)
			touchWay(32'(addr[9:4]), way);
	endtask

	task automatic testUncached();
		readCheck(32'h2000_0010);
		writeCheck(32'h2000_0010, 32'h1122_3344, 4'b1111);
		readCheck(32'h2000_0010);
		writeCheck(32'he000_0104, 32'hdead_beef, 4'b0110);
		readCheck(32'he000_0104);
		readCheck(32'h8000_0ff8);
	endtask

	task automatic testReadMiss();
		readCheck(32'h0000_1238);
		for (int w = 0; w < 4; w++)
			readCheck(32'h0000_1230 + 32'(4 * w));
		// last word of a line wraps to word 0
		readCheck(32'h0000_204c);
		readCheck(32'h0000_2040);
	endtask

	task automatic testWrite();
		writeCheck(32'h0000_1234, 32'haabb_ccdd, 4'b0101);
		setEnable(1'b0);
		readCheck(32'h0000_1234);
		setEnable(1'b1);
		readCheck(32'h0000_1234);
		readCheck(32'h0000_1238);
		writeCheck(32'h0000_3008, 32'h5566_7788, 4'b1111);
		readCheck(32'h0000_3008);
	endtask

	task automatic testLru();
		for (int t = 0; t < 4; t++)
			readCheck(lineAddr(t) + 32'd4);
		readCheck(lineAddr(0));
		readCheck(lineAddr(2) + 32'd8);
		readCheck(lineAddr(4));
		readCheck(lineAddr(0));
		readCheck(lineAddr(2));
		readCheck(lineAddr(3));
		readCheck(lineAddr(4));
		// tag 1 was the least recent one
		readCheck(lineAddr(1));
	endtask

	task automatic testDisabled();
		setEnable(1'b0);
		readCheck(32'h0000_5010);
		readCheck(32'h0000_5010);
		readCheck(32'h0000_1238);
		setEnable(1'b1);
		readCheck(32'h0000_5010);
	endtask

	initial begin
		cycles = 0;
		while (cycles < timeoutCycles) begin
			@(posedge CLK);
			cycles++;
		end
		$display("error: tests did not finish within %0d cycles", timeoutCycles);
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		cpuAddr = '0;
		cpuWdata = '0;
		cpuBe = '0;
		cpuWr = 1'b0;
		cpuReq = 1'b0;
		cacheEnable = 1'b1;
		initModel();
		wait (RST_N === 1'b1);
		testUncached();
		testReadMiss();
		testWrite();
		testLru();
		testDisabled();
		$display("Simulation passed");
		$finish;
	end

endmodule

// File: cpuCache.f
hdl/cachePkg.sv
hdl/busPkg.sv
hdl/cacheIfs.sv
hdl/cacheArray.sv
hdl/cacheControl.sv
hdl/busMaster.sv
hdl/cpuCache.sv
dv/clockGen.sv
dv/memModel.sv
dv/cacheTb.sv

// File: Makefile
SOURCES := $(shell cat cpuCache.f)

obj_dir/VcacheTb: cpuCache.f $(SOURCES)
	verilator --binary --timing -j 0 --top-module cacheTb -f cpuCache.f

run: obj_dir/VcacheTb
	@out="$$(./obj_dir/VcacheTb)"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
